//--- exu_pipe.f
src/exu_pkg.sv
src/exu_stage_if.sv
src/op_decode.sv
src/exu.sv
src/lsu_stage.sv
src/exu_pipe.sv
tests/exu_pipe_chk.sv
tests/exu_pipe_tb.sv

//--- Bender.yml
package:
  name: exu_pipe

sources:
  - files:
      - src/exu_pkg.sv
      - src/exu_stage_if.sv
      - src/op_decode.sv
      - src/exu.sv
      - src/lsu_stage.sv
      - src/exu_pipe.sv
  - target: test
    files:
      - tests/exu_pipe_chk.sv
      - tests/exu_pipe_tb.sv

//--- tests/exu_pipe_tb.sv
`default_nettype none

module exu_pipe_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_OPS = 400;
	localparam int DEPTH = exu_pkg::STAGE_DEPTH;

	logic                     clk;
	logic                     rst;
	logic                     in_valid;
	logic                     in_credit;
	logic [6:0]               opcode;
	logic [2:0]               funct3;
	logic [6:0]               funct7;
	logic [exu_pkg::XLEN-1:0] imm;
	logic [exu_pkg::XLEN-1:0] src1;
	logic [exu_pkg::XLEN-1:0] src2;
	logic [exu_pkg::XLEN-1:0] pc;
	logic [4:0]               rd;
	logic                     out_valid;
	logic                     out_credit;
	logic [exu_pkg::XLEN-1:0] out_val;
	logic [exu_pkg::XLEN-1:0] out_jump;
	logic [4:0]               out_rd;

	logic [31:0] mem_model [exu_pkg::MEM_WORDS];
	logic [31:0] exp_val [$];
	logic [31:0] exp_jump [$];
	logic [4:0]  exp_rd [$];
	int          src_credits;
	int          held; // results sitting in the consumer
	int          granted;
	int          issued;
	int          received;
	int          value_errs;
	int          proto_errs;
	bit          timed_out;

	exu_pipe exu_pipe_i (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			value_errs++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic gen_op();
		int          kind;
		int          sel;
		logic [31:0] tmp;
		kind   = $urandom % 12;
		sel    = $urandom % 4;
		tmp    = $urandom;
		funct3 = 3'($urandom);
		funct7 = (sel < 2) ? 7'h00 : (sel == 2) ? 7'h20 : 7'($urandom);
		imm    = {{20{tmp[11]}}, tmp[11:0]};
		src1   = $urandom;
		src2   = ($urandom % 4 == 0) ? src1 : $urandom; // equal operands for branches
		pc     = $urandom & 32'hffff_fffc;
		rd     = 5'($urandom);
		case (kind)
			0, 1: opcode = 7'h33;
			2, 3: opcode = 7'h13;
			4: begin
				opcode = ($urandom % 2) ? 7'h37 : 7'h17;
				imm    = {tmp[31:12], 12'h000};
			end
			5: opcode = 7'h6f;
			6: begin
				opcode = 7'h67;
				if ($urandom % 4 != 0) funct3 = 3'd0;
			end
			7: opcode = 7'h63;
			8, 9, 10: begin
				opcode = (kind == 10) ? 7'h23 : 7'h03;
				src1   = 32'h80 + ($urandom % 8); // small window so accesses collide
				imm    = $urandom % 8;
			end
			default: opcode = 7'($urandom);
		endcase
	endtask

	task automatic predict();
		logic [31:0] b;
		logic [31:0] ea;
		logic [31:0] w;
		logic [31:0] v;
		logic [31:0] j;
		logic [7:0]  idx;
		logic [7:0]  by;
		logic [15:0] hw;
		logic        is_imm;
		logic        alt;
		logic        legal;
		logic        tk;
		is_imm = (opcode == 7'h13);
		b      = is_imm ? imm : src2;
		ea     = src1 + imm;
		idx    = ea[9:2];
		w      = mem_model[idx];
		by     = 8'(w >> (8 * ea[1:0]));
		hw     = 16'(w >> (16 * ea[1]));
		alt    = (funct7 == 7'h20);
		v      = '0;
		j      = '0;
		tk     = 1'b0;
		case (opcode)
			7'h37: v = imm;
			7'h17: v = pc + imm;
			7'h6f: begin
				v = pc + 4;
				j = pc + imm;
			end
			7'h67: begin
				if (funct3 == 3'd0) begin
					v = pc + 4;
					j = {ea[31:1], 1'b0};
				end
			end
			7'h63: begin
				case (funct3)
					3'd0: tk = (src1 == src2);
					3'd1: tk = (src1 != src2);
					3'd4: tk = ($signed(src1) < $signed(src2));
					3'd5: tk = ($signed(src1) >= $signed(src2));
					3'd6: tk = (src1 < src2);
					3'd7: tk = (src1 >= src2);
					default: tk = 1'b0;
				endcase
				if (tk) j = pc + imm;
			end
			7'h03: begin
				case (funct3)
					3'd0: v = {{24{by[7]}}, by};
					3'd1: v = {{16{hw[15]}}, hw};
					3'd2: v = w;
					3'd4: v = {24'h0, by};
					3'd5: v = {16'h0, hw};
					default: ;
				endcase
			end
			7'h23: begin
				case (funct3)
					3'd0: mem_model[idx][8*ea[1:0] +: 8] = src2[7:0];
					3'd1: mem_model[idx][16*ea[1] +: 16] = src2[15:0];
					3'd2: mem_model[idx] = src2;
					default: ;
				endcase
			end
			7'h13, 7'h33: begin
				if (is_imm) legal = !((funct3 == 3'd1 && funct7 != 7'h00)
					|| (funct3 == 3'd5 && funct7 != 7'h00 && !alt));
				else legal = (funct7 == 7'h00) || (alt && (funct3 == 3'd0 || funct3 == 3'd5));
				if (legal) begin
					case (funct3)
						3'd0: v = (alt && !is_imm) ? src1 - b : src1 + b;
						3'd1: v = src1 << b[4:0];
						3'd2: v = {31'h0, $signed(src1) < $signed(b)};
						3'd3: v = {31'h0, src1 < b};
						3'd4: v = src1 ^ b;
						3'd5: begin
							if (alt) v = $signed(src1) >>> b[4:0];
							else v = src1 >> b[4:0];
						end
						3'd6: v = src1 | b;
						default: v = src1 & b;
					endcase
				end
			end
			default: ;
		endcase
		exp_val.push_back(v);
		exp_jump.push_back(j);
		exp_rd.push_back(rd);
	endtask

	task automatic receive();
		received++;
		held++;
		if (received > granted + DEPTH) begin
			proto_errs++;
			$display("result at %0t was delivered without a consumer credit", $time);
		end
		if (exp_val.size() == 0) begin
			proto_errs++;
			$display("result at %0t arrived with no operation outstanding", $time);
		end else begin
			check("out_val", exp_val.pop_front(), out_val);
			check("out_jump", exp_jump.pop_front(), out_jump);
			check("out_rd", 32'(exp_rd.pop_front()), 32'(out_rd));
		end
	endtask

	// one cycle of source and consumer 1 ns after the edge
	task automatic step(input int issue_pct, input int free_pct);
		@(posedge clk);
		#1;
		if (in_credit) src_credits++;
		if (src_credits > DEPTH) begin
			proto_errs++;
			$display("in_credit returned more credits than the source spent at %0t", $time);
		end
		if (out_valid) receive();
		out_credit = 1'b0;
		if (held > 0 && int'($urandom % 100) < free_pct) begin
			out_credit = 1'b1;
			held--;
			granted++;
		end
		in_valid = 1'b0;
		if (src_credits > 0 && issued < N_OPS && int'($urandom % 100) < issue_pct) begin
			gen_op();
			predict();
			in_valid = 1'b1;
			src_credits--;
			issued++;
		end
	endtask

	task automatic run_random();
		int cycles;
		cycles = 0;
		while (issued < N_OPS && !timed_out) begin
			step(75, 40);
			cycles++;
			if (cycles > 40 * N_OPS) begin
				timed_out = 1'b1;
				proto_errs++;
				$display("timeout: the source never got credits to issue every operation");
			end
		end
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while (received < issued && !timed_out) begin
			step(0, 50);
			cycles++;
			if (cycles > 1000) begin
				timed_out = 1'b1;
				proto_errs++;
				$display("timeout: the pipeline did not deliver all issued operations");
			end
		end
	endtask

	initial begin
		void'($urandom(58851));
		rst        = 1'b1;
		in_valid   = 1'b0;
		out_credit = 1'b0;
		opcode     = '0;
		funct3     = '0;
		funct7     = '0;
		imm        = '0;
		src1       = '0;
		src2       = '0;
		pc         = '0;
		rd         = '0;
		src_credits = DEPTH;
		foreach (mem_model[i]) mem_model[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		check("out_valid after reset", 32'd0, 32'(out_valid));
		check("in_credit after reset", 32'd0, 32'(in_credit));

		// consumer withholds every credit so all buffers fill
		repeat (40) step(100, 0);
		check("ops issued under stall", 32'(4 * DEPTH), 32'(issued));
		check("results under stall", 32'(DEPTH), 32'(received));
		check("source credits under stall", 32'd0, 32'(src_credits));

		run_random();
		drain();
		check("results outstanding", 32'd0, 32'(exp_val.size()));

		$display("errors: value %0d, protocol %0d, assertion %0d (%0d of %0d results)",
			value_errs, proto_errs, exu_pipe_i.exu_pipe_chk_i.fails, received, issued);
		if (value_errs + proto_errs + exu_pipe_i.exu_pipe_chk_i.fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/exu_pipe_chk.sv
`default_nettype none

module exu_pipe_chk (
	input logic                         clk,
	input logic                         rst,
	input logic                         dec_valid,
	input logic [exu_pkg::CREDIT_W-1:0] dec_credits,
	input logic                         ex_valid,
	input logic [exu_pkg::CREDIT_W-1:0] ex_credits,
	input logic                         out_valid,
	input logic [exu_pkg::CREDIT_W-1:0] mem_credits
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fails = 0;

	a_dec_valid: assert property (@(posedge clk) disable iff (rst)
		dec_valid |-> dec_credits != '0) else begin
		$error("decode stage raised valid with no downstream credit");
		fails++;
	end

	a_ex_valid: assert property (@(posedge clk) disable iff (rst)
		ex_valid |-> ex_credits != '0) else begin
		$error("execute stage raised valid with no downstream credit");
		fails++;
	end

	a_out_valid: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> mem_credits != '0) else begin
		$error("memory stage raised out_valid with no consumer credit");
		fails++;
	end

	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		dec_credits <= exu_pkg::STAGE_DEPTH && ex_credits <= exu_pkg::STAGE_DEPTH
		&& mem_credits <= exu_pkg::STAGE_DEPTH) else begin
		$error("a credit counter rose above the buffer depth");
		fails++;
	end

	a_reset_out: assert property (@(posedge clk) rst |=> !out_valid) else begin
		$error("out_valid high in the cycle after reset");
		fails++;
	end

endmodule

bind exu_pipe exu_pipe_chk exu_pipe_chk_i (
	.clk         (clk),
	.rst         (rst),
	.dec_valid   (dec_to_ex.valid),
	.dec_credits (op_decode_i.credit_cnt),
	.ex_valid    (ex_to_mem.valid),
	.ex_credits  (exu_i.credit_cnt),
	.out_valid   (out_valid),
	.mem_credits (lsu_stage_i.credit_cnt)
);

`default_nettype wire

//--- src/exu_pipe.sv
`default_nettype none

module exu_pipe (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	output logic                     in_credit,
	input  logic [6:0]               opcode,
	input  logic [2:0]               funct3,
	input  logic [6:0]               funct7,
	input  logic [exu_pkg::XLEN-1:0] imm,
	input  logic [exu_pkg::XLEN-1:0] src1,
	input  logic [exu_pkg::XLEN-1:0] src2,
	input  logic [exu_pkg::XLEN-1:0] pc,
	input  logic [4:0]               rd,
	output logic                     out_valid,
	input  logic                     out_credit,
	output logic [exu_pkg::XLEN-1:0] out_val,
	output logic [exu_pkg::XLEN-1:0] out_jump,
	output logic [4:0]               out_rd
);
	exu_stage_if dec_to_ex ();
	exu_stage_if ex_to_mem ();

	op_decode op_decode_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_credit (in_credit),
		.opcode    (opcode),
		.funct3    (funct3),
		.funct7    (funct7),
		.imm       (imm),
		.src1      (src1),
		.src2      (src2),
		.pc        (pc),
		.rd        (rd),
		.down      (dec_to_ex.sender)
	);

	exu exu_i (
		.clk  (clk),
		.rst  (rst),
		.up   (dec_to_ex.receiver),
		.down (ex_to_mem.sender)
	);

	lsu_stage lsu_stage_i (
		.clk        (clk),
		.rst        (rst),
		.up         (ex_to_mem.receiver),
		.out_valid  (out_valid),
		.out_credit (out_credit),
		.out_val    (out_val),
		.out_jump   (out_jump),
		.out_rd     (out_rd)
	);

endmodule

`default_nettype wire

//--- src/lsu_stage.sv
`default_nettype none

module lsu_stage (
	input  logic                     clk,
	input  logic                     rst,
	exu_stage_if.receiver            up,
	output logic                     out_valid,
	input  logic                     out_credit,
	output logic [exu_pkg::XLEN-1:0] out_val,
	output logic [exu_pkg::XLEN-1:0] out_jump,
	output logic [4:0]               out_rd
);
	exu_pkg::mem_op_e         q_mem  [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_val  [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_jump [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_addr [exu_pkg::STAGE_DEPTH];
	logic [4:0]               q_rd   [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] mem    [exu_pkg::MEM_WORDS];

	logic [$clog2(exu_pkg::STAGE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(exu_pkg::STAGE_DEPTH)-1:0] rd_ptr;
	logic [exu_pkg::CREDIT_W-1:0]            count;
	logic [exu_pkg::CREDIT_W-1:0]            credit_cnt; // consumer slots
	logic                                    pop;
	exu_pkg::mem_op_e                        h_mem;
	logic [exu_pkg::XLEN-1:0]                h_val;
	logic [exu_pkg::XLEN-1:0]                h_addr;
	logic [$clog2(exu_pkg::MEM_WORDS)-1:0]   widx;
	logic [exu_pkg::XLEN-1:0]                rword;
	logic [7:0]                              rbyte;
	logic [15:0]                             rhalf;
	logic [3:0]                              wmask;
	logic [exu_pkg::XLEN-1:0]                wdata;
	logic [exu_pkg::XLEN-1:0]                res_val;

	assign h_mem  = q_mem[rd_ptr];
	assign h_val  = q_val[rd_ptr];
	assign h_addr = q_addr[rd_ptr];
	assign widx   = h_addr[$clog2(exu_pkg::MEM_WORDS)+1:2];
	assign rword  = mem[widx];
	assign rbyte  = rword[8*h_addr[1:0] +: 8];
	assign rhalf  = h_addr[1] ? rword[31:16] : rword[15:0];

	assign pop = (count != '0) && (credit_cnt > exu_pkg::CREDIT_W'(out_valid));

	always_comb begin
		wmask = 4'b0000;
		wdata = h_val;
		case (h_mem)
			exu_pkg::MEM_SB: begin
				wmask = 4'b0001 << h_addr[1:0];
				wdata = {4{h_val[7:0]}}; // replicate into every lane
			end
			exu_pkg::MEM_SH: begin
				wmask = h_addr[1] ? 4'b1100 : 4'b0011;
				wdata = {2{h_val[15:0]}};
			end
			exu_pkg::MEM_SW: wmask = 4'b1111;
			default: ;
		endcase
	end

	always_comb begin
		case (h_mem)
			exu_pkg::MEM_LB:  res_val = {{(exu_pkg::XLEN-8){rbyte[7]}}, rbyte};
			exu_pkg::MEM_LH:  res_val = {{(exu_pkg::XLEN-16){rhalf[15]}}, rhalf};
			exu_pkg::MEM_LW:  res_val = rword;
			exu_pkg::MEM_LBU: res_val = {{(exu_pkg::XLEN-8){1'b0}}, rbyte};
			exu_pkg::MEM_LHU: res_val = {{(exu_pkg::XLEN-16){1'b0}}, rhalf};
			exu_pkg::MEM_SB,
			exu_pkg::MEM_SH,
			exu_pkg::MEM_SW:  res_val = '0;
			default:          res_val = h_val;
		endcase
	end

	// memory starts out zeroed
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < exu_pkg::MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (pop) begin
			for (int b = 0; b < 4; b++) begin
				if (wmask[b]) mem[widx][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (up.valid) begin
			q_mem[wr_ptr]  <= up.mem_op;
			q_val[wr_ptr]  <= up.val;
			q_jump[wr_ptr] <= up.jump;
			q_addr[wr_ptr] <= up.addr;
			q_rd[wr_ptr]   <= up.rd;
		end
		if (pop) begin
			out_val  <= res_val;
			out_jump <= q_jump[rd_ptr];
			out_rd   <= q_rd[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_cnt <= exu_pkg::CREDIT_W'(exu_pkg::STAGE_DEPTH);
			up.credit  <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			if (up.valid) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			count      <= count + exu_pkg::CREDIT_W'(up.valid) - exu_pkg::CREDIT_W'(pop);
			credit_cnt <= credit_cnt - exu_pkg::CREDIT_W'(out_valid)
				+ exu_pkg::CREDIT_W'(out_credit);
			up.credit  <= pop;
			out_valid  <= pop;
		end
	end

endmodule

`default_nettype wire

//--- src/exu.sv
`default_nettype none

module exu (
	input logic           clk,
	input logic           rst,
	exu_stage_if.receiver up,
	exu_stage_if.sender   down
);
	exu_pkg::alu_op_e         q_alu  [exu_pkg::STAGE_DEPTH];
	exu_pkg::mem_op_e         q_mem  [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_src1 [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_src2 [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_imm  [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_pc   [exu_pkg::STAGE_DEPTH];
	logic [4:0]               q_rd   [exu_pkg::STAGE_DEPTH];

	logic [$clog2(exu_pkg::STAGE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(exu_pkg::STAGE_DEPTH)-1:0] rd_ptr;
	logic [exu_pkg::CREDIT_W-1:0]            count;
	logic [exu_pkg::CREDIT_W-1:0]            credit_cnt;
	logic                                    pop;
	exu_pkg::alu_op_e                        h_alu;
	logic [exu_pkg::XLEN-1:0]                h_src1;
	logic [exu_pkg::XLEN-1:0]                h_src2;
	logic [exu_pkg::XLEN-1:0]                h_imm;
	logic [exu_pkg::XLEN-1:0]                h_pc;
	logic [4:0]                              shamt;
	logic [exu_pkg::XLEN-1:0]                target;
	logic [exu_pkg::XLEN-1:0]                ea; // src1 + imm
	logic [exu_pkg::XLEN-1:0]                ex_val;
	logic [exu_pkg::XLEN-1:0]                ex_jump;
	logic                                    taken;

	assign h_alu  = q_alu[rd_ptr];
	assign h_src1 = q_src1[rd_ptr];
	assign h_src2 = q_src2[rd_ptr];
	assign h_imm  = q_imm[rd_ptr];
	assign h_pc   = q_pc[rd_ptr];
	assign shamt  = h_src2[4:0];
	assign target = h_pc + h_imm;
	assign ea     = h_src1 + h_imm;

	assign pop = (count != '0) && (credit_cnt > exu_pkg::CREDIT_W'(down.valid));

	always_comb begin
		ex_val = '0;
		taken  = 1'b0;
		case (h_alu)
			exu_pkg::ALU_ADD:   ex_val = h_src1 + h_src2;
			exu_pkg::ALU_SUB:   ex_val = h_src1 - h_src2;
			exu_pkg::ALU_SLL:   ex_val = h_src1 << shamt;
			exu_pkg::ALU_SLT:   ex_val = exu_pkg::XLEN'($signed(h_src1) < $signed(h_src2));
			exu_pkg::ALU_SLTU:  ex_val = exu_pkg::XLEN'(h_src1 < h_src2);
			exu_pkg::ALU_XOR:   ex_val = h_src1 ^ h_src2;
			exu_pkg::ALU_SRL:   ex_val = h_src1 >> shamt;
			exu_pkg::ALU_SRA:   ex_val = $signed(h_src1) >>> shamt;
			exu_pkg::ALU_OR:    ex_val = h_src1 | h_src2;
			exu_pkg::ALU_AND:   ex_val = h_src1 & h_src2;
			exu_pkg::ALU_LUI:   ex_val = h_imm;
			exu_pkg::ALU_AUIPC: ex_val = target;
			exu_pkg::ALU_JAL,
			exu_pkg::ALU_JALR:  ex_val = h_pc + exu_pkg::XLEN'(4); // link
			exu_pkg::ALU_BEQ:   taken = (h_src1 == h_src2);
			exu_pkg::ALU_BNE:   taken = (h_src1 != h_src2);
			exu_pkg::ALU_BLT:   taken = ($signed(h_src1) < $signed(h_src2));
			exu_pkg::ALU_BGE:   taken = ($signed(h_src1) >= $signed(h_src2));
			exu_pkg::ALU_BLTU:  taken = (h_src1 < h_src2);
			exu_pkg::ALU_BGEU:  taken = (h_src1 >= h_src2);
			exu_pkg::ALU_LOAD,
			exu_pkg::ALU_STORE: ex_val = h_src2; // store data
			default: ;
		endcase
	end

	always_comb begin
		case (h_alu)
			exu_pkg::ALU_JAL:  ex_jump = target;
			exu_pkg::ALU_JALR: ex_jump = ea & ~exu_pkg::XLEN'(1);
			default:           ex_jump = taken ? target : '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (up.valid) begin
			q_alu[wr_ptr]  <= up.alu_op;
			q_mem[wr_ptr]  <= up.mem_op;
			q_src1[wr_ptr] <= up.src1;
			q_src2[wr_ptr] <= up.src2;
			q_imm[wr_ptr]  <= up.imm;
			q_pc[wr_ptr]   <= up.pc;
			q_rd[wr_ptr]   <= up.rd;
		end
		if (pop) begin
			down.alu_op <= h_alu;
			down.mem_op <= q_mem[rd_ptr];
			down.rd     <= q_rd[rd_ptr];
			down.val    <= ex_val;
			down.jump   <= ex_jump;
			down.addr   <= ea;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_cnt <= exu_pkg::CREDIT_W'(exu_pkg::STAGE_DEPTH);
			up.credit  <= 1'b0;
			down.valid <= 1'b0;
		end else begin
			if (up.valid) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			count      <= count + exu_pkg::CREDIT_W'(up.valid) - exu_pkg::CREDIT_W'(pop);
			credit_cnt <= credit_cnt - exu_pkg::CREDIT_W'(down.valid)
				+ exu_pkg::CREDIT_W'(down.credit);
			up.credit  <= pop;
			down.valid <= pop;
		end
	end

	// operands end here
	assign down.src1 = '0;
	assign down.src2 = '0;
	assign down.imm  = '0;
	assign down.pc   = '0;

endmodule

`default_nettype wire

//--- src/op_decode.sv
`default_nettype none

module op_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	output logic                     in_credit,
	input  logic [6:0]               opcode,
	input  logic [2:0]               funct3,
	input  logic [6:0]               funct7,
	input  logic [exu_pkg::XLEN-1:0] imm,
	input  logic [exu_pkg::XLEN-1:0] src1,
	input  logic [exu_pkg::XLEN-1:0] src2,
	input  logic [exu_pkg::XLEN-1:0] pc,
	input  logic [4:0]               rd,
	exu_stage_if.sender              down
);
	logic [6:0]               q_opcode [exu_pkg::STAGE_DEPTH];
	logic [2:0]               q_funct3 [exu_pkg::STAGE_DEPTH];
	logic [6:0]               q_funct7 [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_imm    [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_src1   [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_src2   [exu_pkg::STAGE_DEPTH];
	logic [exu_pkg::XLEN-1:0] q_pc     [exu_pkg::STAGE_DEPTH];
	logic [4:0]               q_rd     [exu_pkg::STAGE_DEPTH];

	logic [$clog2(exu_pkg::STAGE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(exu_pkg::STAGE_DEPTH)-1:0] rd_ptr;
	logic [exu_pkg::CREDIT_W-1:0]            count;
	logic [exu_pkg::CREDIT_W-1:0]            credit_cnt;
	logic                                    pop;
	logic [6:0]                              h_opcode;
	logic [2:0]                              h_funct3;
	logic [6:0]                              h_funct7;
	exu_pkg::alu_op_e                        dec_alu;
	exu_pkg::mem_op_e                        dec_mem;

	assign h_opcode = q_opcode[rd_ptr];
	assign h_funct3 = q_funct3[rd_ptr];
	assign h_funct7 = q_funct7[rd_ptr];

	// keep one credit back for a valid already on the wire
	assign pop = (count != '0) && (credit_cnt > exu_pkg::CREDIT_W'(down.valid));

	always_comb begin
		dec_alu = exu_pkg::ALU_NONE;
		dec_mem = exu_pkg::MEM_NONE;
		case (h_opcode)
			exu_pkg::LUI:   dec_alu = exu_pkg::ALU_LUI;
			exu_pkg::AUIPC: dec_alu = exu_pkg::ALU_AUIPC;
			exu_pkg::JAL:   dec_alu = exu_pkg::ALU_JAL;
			exu_pkg::JALR: begin
				if (h_funct3 == 3'd0) dec_alu = exu_pkg::ALU_JALR;
			end
			exu_pkg::BRANCH: begin
				case (h_funct3)
					3'd0: dec_alu = exu_pkg::ALU_BEQ;
					3'd1: dec_alu = exu_pkg::ALU_BNE;
					3'd4: dec_alu = exu_pkg::ALU_BLT;
					3'd5: dec_alu = exu_pkg::ALU_BGE;
					3'd6: dec_alu = exu_pkg::ALU_BLTU;
					3'd7: dec_alu = exu_pkg::ALU_BGEU;
					default: ;
				endcase
			end
			exu_pkg::LOAD: begin
				case (h_funct3)
					3'd0: dec_mem = exu_pkg::MEM_LB;
					3'd1: dec_mem = exu_pkg::MEM_LH;
					3'd2: dec_mem = exu_pkg::MEM_LW;
					3'd4: dec_mem = exu_pkg::MEM_LBU;
					3'd5: dec_mem = exu_pkg::MEM_LHU;
					default: ;
				endcase
				if (dec_mem != exu_pkg::MEM_NONE) dec_alu = exu_pkg::ALU_LOAD;
			end
			exu_pkg::STORE: begin
				case (h_funct3)
					3'd0: dec_mem = exu_pkg::MEM_SB;
					3'd1: dec_mem = exu_pkg::MEM_SH;
					3'd2: dec_mem = exu_pkg::MEM_SW;
					default: ;
				endcase
				if (dec_mem != exu_pkg::MEM_NONE) dec_alu = exu_pkg::ALU_STORE;
			end
			exu_pkg::OP_IMM: begin
				case (h_funct3)
					3'd0: dec_alu = exu_pkg::ALU_ADD;
					3'd1: if (h_funct7 == 7'h00) dec_alu = exu_pkg::ALU_SLL;
					3'd2: dec_alu = exu_pkg::ALU_SLT;
					3'd3: dec_alu = exu_pkg::ALU_SLTU;
					3'd4: dec_alu = exu_pkg::ALU_XOR;
					3'd5: begin
						if (h_funct7 == 7'h00) dec_alu = exu_pkg::ALU_SRL;
						else if (h_funct7 == 7'h20) dec_alu = exu_pkg::ALU_SRA;
					end
					3'd6: dec_alu = exu_pkg::ALU_OR;
					default: dec_alu = exu_pkg::ALU_AND;
				endcase
			end
			exu_pkg::OP: begin
				if (h_funct7 == 7'h00) begin
					case (h_funct3)
						3'd0: dec_alu = exu_pkg::ALU_ADD;
						3'd1: dec_alu = exu_pkg::ALU_SLL;
						3'd2: dec_alu = exu_pkg::ALU_SLT;
						3'd3: dec_alu = exu_pkg::ALU_SLTU;
						3'd4: dec_alu = exu_pkg::ALU_XOR;
						3'd5: dec_alu = exu_pkg::ALU_SRL;
						3'd6: dec_alu = exu_pkg::ALU_OR;
						default: dec_alu = exu_pkg::ALU_AND;
					endcase
				end else if (h_funct7 == 7'h20) begin
					if (h_funct3 == 3'd0) dec_alu = exu_pkg::ALU_SUB;
					else if (h_funct3 == 3'd5) dec_alu = exu_pkg::ALU_SRA;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			q_opcode[wr_ptr] <= opcode;
			q_funct3[wr_ptr] <= funct3;
			q_funct7[wr_ptr] <= funct7;
			q_imm[wr_ptr]    <= imm;
			q_src1[wr_ptr]   <= src1;
			q_src2[wr_ptr]   <= src2;
			q_pc[wr_ptr]     <= pc;
			q_rd[wr_ptr]     <= rd;
		end
		if (pop) begin
			down.alu_op <= dec_alu;
			down.mem_op <= dec_mem;
			down.src1   <= q_src1[rd_ptr];
			// OP-IMM carries imm as operand b
			down.src2   <= (h_opcode == exu_pkg::OP_IMM) ? q_imm[rd_ptr] : q_src2[rd_ptr];
			down.imm    <= q_imm[rd_ptr];
			down.pc     <= q_pc[rd_ptr];
			down.rd     <= q_rd[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_cnt <= exu_pkg::CREDIT_W'(exu_pkg::STAGE_DEPTH);
			in_credit  <= 1'b0;
			down.valid <= 1'b0;
		end else begin
			if (in_valid) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			count      <= count + exu_pkg::CREDIT_W'(in_valid) - exu_pkg::CREDIT_W'(pop);
			credit_cnt <= credit_cnt - exu_pkg::CREDIT_W'(down.valid)
				+ exu_pkg::CREDIT_W'(down.credit);
			in_credit  <= pop;
			down.valid <= pop;
		end
	end

	assign down.val  = '0;
	assign down.jump = '0;
	assign down.addr = '0;

endmodule

`default_nettype wire

//--- src/exu_stage_if.sv
`default_nettype none

interface exu_stage_if;
	logic                     valid;
	logic                     credit; // one-cycle return pulse
	exu_pkg::alu_op_e         alu_op;
	exu_pkg::mem_op_e         mem_op;
	logic [exu_pkg::XLEN-1:0] src1;
	logic [exu_pkg::XLEN-1:0] src2;
	logic [exu_pkg::XLEN-1:0] imm;
	logic [exu_pkg::XLEN-1:0] pc;
	logic [4:0]               rd;
	logic [exu_pkg::XLEN-1:0] val;
	logic [exu_pkg::XLEN-1:0] jump;
	logic [exu_pkg::XLEN-1:0] addr;

	modport sender (
		output valid, alu_op, mem_op, src1, src2, imm, pc, rd, val, jump, addr,
		input  credit
	);

	modport receiver (
		input  valid, alu_op, mem_op, src1, src2, imm, pc, rd, val, jump, addr,
		output credit
	);
endinterface

`default_nettype wire

//--- src/exu_pkg.sv
`default_nettype none

package exu_pkg;

	localparam int XLEN        = 32;
	localparam int STAGE_DEPTH = 2; // entries per stage buffer
	localparam int CREDIT_W    = 2;
	localparam int MEM_WORDS   = 256; // indexed by addr[9:2]

	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_LUI,
		ALU_AUIPC,
		ALU_JAL,
		ALU_JALR,
		ALU_BEQ,
		ALU_BNE,
		ALU_BLT,
		ALU_BGE,
		ALU_BLTU,
		ALU_BGEU,
		ALU_LOAD,
		ALU_STORE,
		ALU_NONE
	} alu_op_e;

	// nine actions need four bits
	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

endpackage

`default_nettype wire
